/* all.f */
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_byte_if.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_cmd_ctrl.sv
hdl/uart_top.sv
verif/uart_asserts.sv
verif/uart_tb.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then judge the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module uart_tb -f all.f -o uart_sim \
  > build.log 2>&1 || echo "sim failed" > sim.log
[ -s sim.log ] || ./obj_dir/uart_sim > sim.log 2>&1 || echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

/* verif/uart_tb.sv */
`timescale 1ns/10ps

`include "uart_defines.svh"

module uart_tb;

  localparam int baud      = 8;
  localparam int frame_cyc = 11 * baud;
  // twelve commands, none longer than a header plus the response timeout.
  localparam int cmd_bits   = 11 + `UART_RSP_TIMEOUT_BITS + 5;
  localparam int max_cycles = 12 * cmd_bits * baud * 2;

  logic                        clk;
  logic                        rst_n;
  logic [`UART_CMD_WIDTH-1:0]  cmd_in;
  logic                        cmd_vld;
  logic                        rx;
  logic                        tx;
  logic                        cmd_rdy;
  logic                        read_rdy;
  logic [`UART_READ_WIDTH-1:0] read_data;
  logic                        read_err;

  int errors;
  int checks;
  int cycle;
  int seed;

  uart_top #(
    .baud_div (baud)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  initial
  begin
    wait (cycle >= max_cycles);
    $display("timeout: no result after %0d clock cycles", max_cycles);
    $display("sim failed");
    $finish;
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s finished, %0d errors so far", name, errors);
  endtask

  task automatic issue_cmd(input logic [15:0] c);
    @(negedge clk);
    while (!cmd_rdy)
      @(negedge clk);
    @(posedge clk);
    #1;
    cmd_in  = c;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
    @(negedge clk);
    check(32'(cmd_rdy), 0, "cmd_rdy after accept");
  endtask

  // ignored by the DUT since cmd_rdy is low.
  task automatic pulse_while_busy(input logic [15:0] c);
    @(posedge clk);
    #1;
    cmd_in  = c;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  // samples each bit near its middle.
  task automatic decode_frame(output logic [7:0] b, output logic par_ok,
                              output logic stop, output int start_cyc);
    logic par;
    @(negedge clk);
    while (tx)
      @(negedge clk);
    start_cyc = cycle;
    repeat (baud / 2 - 1) @(negedge clk);
    for (int i = 0; i < 8; i++)
    begin
      repeat (baud) @(negedge clk);
      b[i] = tx;
    end
    repeat (baud) @(negedge clk);
    par = tx;
    repeat (baud) @(negedge clk);
    stop = tx;
    par_ok = (par == ^b);
  endtask

  // line stays high from the stop bit on.
  task automatic send_frame(input logic [7:0] b, input logic bad_par);
    logic [9:0] bits;
    bits = {^b ^ bad_par, b, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
      @(posedge clk);
      #1;
      rx = bits[i];
      repeat (baud - 1) @(posedge clk);
    end
    @(posedge clk);
    #1;
    rx = 1'b1;
  endtask

  task automatic wait_read(output logic [7:0] d, output logic e, output int at_cyc);
    @(negedge clk);
    while (!read_rdy)
      @(negedge clk);
    d      = read_data;
    e      = read_err;
    at_cyc = cycle;
    @(negedge clk);
    check(32'(read_rdy), 0, "read_rdy one cycle later");
  endtask

  task automatic write_and_check(input logic [15:0] c, input logic busy_pulse);
    logic [7:0] b;
    logic       pok;
    logic       stp;
    int         t0;
    int         t1;
    issue_cmd(c);
    decode_frame(b, pok, stp, t0);
    check(32'(b), 32'({1'b1, c[14:8]}), "write header");
    check(32'(pok & stp), 1, "write header parity and stop");
    if (busy_pulse)
      pulse_while_busy(~c);
    decode_frame(b, pok, stp, t1);
    check(32'(b), 32'(c[7:0]), "write data");
    check(32'(pok & stp), 1, "write data parity and stop");
    check(32'(t1 - t0 - frame_cyc >= `UART_GAP_BITS * baud), 1, "write gap long enough");
    repeat (baud) @(negedge clk);
    check(32'(cmd_rdy), 1, "cmd_rdy after write");
  endtask

  task automatic read_and_check(input logic [15:0] c, input logic [7:0] rsp,
                                input logic bad_par, input logic answer,
                                input logic busy_pulse);
    logic [7:0] b;
    logic       pok;
    logic       stp;
    logic [7:0] d;
    logic       e;
    int         t0;
    int         t1;
    issue_cmd(c);
    decode_frame(b, pok, stp, t0);
    check(32'(b), 32'({1'b0, c[14:8]}), "read header");
    check(32'(pok & stp), 1, "read header parity and stop");
    if (busy_pulse)
      pulse_while_busy(~c);
    // header stop bit ends and the receiver gets armed.
    repeat (2 * baud) @(negedge clk);
    if (answer)
      send_frame(rsp, bad_par);
    wait_read(d, e, t1);
    if (!answer)
    begin
      check(32'(d), 0, "read_data on timeout");
      check(32'(e), 1, "read_err on timeout");
      check(32'(t1 - t0 >= (11 + `UART_RSP_TIMEOUT_BITS) * baud &&
                t1 - t0 <= (11 + `UART_RSP_TIMEOUT_BITS + 4) * baud), 1, "timeout delay");
    end
    else if (bad_par)
    begin
      check(32'(e), 1, "read_err on bad parity");
    end
    else
    begin
      check(32'(d), 32'(rsp), "read_data");
      check(32'(e), 0, "read_err");
    end
  endtask

  task automatic reset_values();
    check(32'(cmd_rdy), 1, "cmd_rdy after reset");
    check(32'(tx), 1, "tx after reset");
    check(32'(read_rdy), 0, "read_rdy after reset");
    check(32'(read_err), 0, "read_err after reset");
    report_test("reset");
  endtask

  task automatic mixed_commands();
    logic [31:0] r;
    logic        extra;
    extra = 1'b0;
    for (int n = 0; n < 8; n++)
    begin
      r = $random(seed);
      if (r[15])
        write_and_check(r[15:0], 1'b1);
      else
        read_and_check(r[15:0], r[23:16], 1'b0, 1'b1, 1'b1);
    end
    repeat (20 * baud) @(negedge clk)
      if (!tx)
        extra = 1'b1;
    check(32'(extra), 0, "frame after the last command");
    report_test("mixed");
  endtask

  initial
  begin
    seed    = 32'h1f86_643e;
    errors  = 0;
    checks  = 0;
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    reset_values();
    write_and_check({1'b1, 7'h2a, 8'hc5}, 1'b0);
    report_test("write");
    read_and_check({1'b0, 7'h15, 8'h00}, 8'h3c, 1'b0, 1'b1, 1'b0);
    report_test("read");
    read_and_check({1'b0, 7'h41, 8'h00}, 8'h96, 1'b1, 1'b1, 1'b0);
    report_test("parity error");
    read_and_check({1'b0, 7'h7f, 8'h00}, 8'h00, 1'b0, 1'b0, 1'b0);
    report_test("timeout");
    mixed_commands();
    // failed assertions count as errors.
    errors = errors + uut.u_ctrl.u_asserts.fail_cnt;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

/* verif/uart_asserts.sv */
`timescale 1ns/10ps

module uart_asserts (
  input logic clk,
  input logic rst_n,
  input logic cmd_rdy,
  input logic read_rdy,
  input logic tx_busy,
  input logic tx_start
);

  // number of failed assertions.
  int fail_cnt = 0;

  // result pulse lasts one cycle.
  read_pulse_once: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("read_rdy high for two cycles in a row");
    end

  no_accept_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    tx_busy |-> !cmd_rdy)
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("cmd_rdy high while the serializer is busy");
    end

  start_only_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy)
    else
    begin
      fail_cnt = fail_cnt + 1;
      $error("serializer start given while busy");
    end

endmodule

bind uart_cmd_ctrl uart_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_rdy  (cmd_rdy),
  .read_rdy (read_rdy),
  .tx_busy  (tx_bus.busy),
  .tx_start (tx_start)
);

/* hdl/uart_top.sv */
`timescale 1ns/10ps

`include "uart_defines.svh"

module uart_top #(
  parameter int baud_div = `UART_BAUD_DIV
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`UART_CMD_WIDTH-1:0]  cmd_in,
  input  logic                        cmd_vld,
  input  logic                        rx,
  output logic                        tx,
  output logic                        cmd_rdy,
  output logic                        read_rdy,
  output logic [`UART_READ_WIDTH-1:0] read_data,
  output logic                        read_err
);

  uart_byte_if tx_bus ();
  uart_byte_if rx_bus ();

  uart_cmd_ctrl #(
    .baud_div (baud_div)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err),
    .tx_bus    (tx_bus),
    .rx_bus    (rx_bus)
  );

  uart_tx #(
    .baud_div (baud_div)
  ) u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (tx_bus),
    .tx    (tx)
  );

  uart_rx #(
    .baud_div (baud_div)
  ) u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .bus   (rx_bus)
  );

endmodule

/* hdl/uart_cmd_ctrl.sv */
`timescale 1ns/10ps

`include "uart_defines.svh"

module uart_cmd_ctrl #(
  parameter int baud_div = `UART_BAUD_DIV
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  uart_pkg::cmd_t              cmd_in,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  output logic                        read_rdy,
  output logic [`UART_READ_WIDTH-1:0] read_data,
  output logic                        read_err,
  uart_byte_if.ctrl_tx                tx_bus,
  uart_byte_if.ctrl_rx                rx_bus
);

  import uart_pkg::*;

  localparam int cnt_w = $clog2(baud_div);
  localparam int bit_w = $clog2(`UART_RSP_TIMEOUT_BITS + 1);

  ctrl_state_t                 state;
  cmd_t                        cmd_q;
  logic [`UART_READ_WIDTH-1:0] tx_data;
  logic                        tx_start;
  logic [cnt_w-1:0]            cyc_cnt;
  logic [bit_w-1:0]            bit_cnt;
  logic                        bit_tick;
  logic                        cnt_run;
  logic                        cnt_hold;
  logic                        accept;
  logic                        gap_end;
  logic                        rsp_timeout;

  // done also takes a command, so the result cycle is ready too.
  assign cmd_rdy  = (state == st_idle) || (state == st_done);
  assign read_rdy = (state == st_done);
  assign accept   = cmd_vld && cmd_rdy;

  assign bit_tick    = (cyc_cnt == cnt_w'(baud_div - 1));
  assign cnt_run     = (state == st_gap) || (state == st_wait_rsp);
  assign cnt_hold    = (state == st_wait_rsp) && rx_bus.busy;
  assign gap_end     = (state == st_gap) && (bit_cnt == bit_w'(`UART_GAP_BITS));
  assign rsp_timeout = (state == st_wait_rsp) && !rx_bus.busy &&
                       (bit_cnt == bit_w'(`UART_RSP_TIMEOUT_BITS));

  // bit time counter for the gap and the response timeout.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (!cnt_run)
    begin
      cyc_cnt <= '0;
      bit_cnt <= '0;
    end
    else if (!cnt_hold)
    begin
      if (bit_tick)
      begin
        cyc_cnt <= '0;
        bit_cnt <= bit_cnt + 1'b1;
      end
      else
      begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= st_idle;
      tx_start  <= 1'b0;
      read_data <= '0;
      read_err  <= 1'b0;
    end
    else
    begin
      tx_start <= accept || gap_end;
      case (state)
        st_idle, st_done:
          state <= accept ? st_send_hdr : st_idle;
        st_send_hdr:
          if (tx_bus.done)
            state <= cmd_q.wr ? st_gap : st_wait_rsp;
        st_gap:
          if (gap_end)
            state <= st_send_data;
        st_send_data:
          if (tx_bus.done)
            state <= st_idle;
        st_wait_rsp:
          if (rx_bus.valid)
          begin
            state     <= st_done;
            read_data <= rx_bus.data;
            read_err  <= rx_bus.done;
          end
          else if (rsp_timeout)
          begin
            state     <= st_done;
            read_data <= '0;
            read_err  <= 1'b1;
          end
        default:
          state <= st_idle;
      endcase
    end
  end

  // header is wr flag and address, data follows after the gap.
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd_in;
      tx_data <= {cmd_in.wr, cmd_in.addr};
    end
    else if (gap_end)
    begin
      tx_data <= cmd_q.data;
    end
  end

  assign tx_bus.start = tx_start;
  assign tx_bus.data  = tx_data;
  // arm rx as the read header finishes.
  assign rx_bus.start = (state == st_send_hdr) && tx_bus.done && !cmd_q.wr;

endmodule

/* hdl/uart_rx.sv */
`timescale 1ns/10ps

`include "uart_defines.svh"

module uart_rx #(
  parameter int baud_div = `UART_BAUD_DIV
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           rx,
  uart_byte_if.rx_engine bus
);

  import uart_pkg::*;

  localparam int cnt_w = $clog2(baud_div);
  localparam int half  = baud_div / 2;

  logic                        rx_meta;
  logic                        rx_sync;
  logic                        rx_prev;
  logic                        armed;
  logic                        active;
  logic                        valid;
  logic                        err;
  logic                        par_bit;
  logic [cnt_w-1:0]            cyc_cnt;
  logic [3:0]                  bit_idx;
  logic [`UART_READ_WIDTH-1:0] shreg;
  logic                        fall;
  logic                        sample;

  assign fall   = rx_prev && !rx_sync;
  // start bit checked at half a bit, the rest a full bit later.
  assign sample = (bit_idx == 4'd0) ? (cyc_cnt == cnt_w'(half - 1))
                                    : (cyc_cnt == cnt_w'(baud_div - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      armed   <= 1'b0;
      active  <= 1'b0;
      valid   <= 1'b0;
      cyc_cnt <= '0;
      bit_idx <= '0;
    end
    else
    begin
      valid <= 1'b0;
      if (active)
      begin
        if (sample)
        begin
          cyc_cnt <= '0;
          if (bit_idx == 4'd0)
          begin
            // glitch, go back to hunting.
            if (rx_sync)
              active <= 1'b0;
            else
              bit_idx <= 4'd1;
          end
          else if (bit_idx == 4'd10)
          begin
            active <= 1'b0;
            armed  <= 1'b0;
            valid  <= 1'b1;
          end
          else
          begin
            bit_idx <= bit_idx + 4'd1;
          end
        end
        else
        begin
          cyc_cnt <= cyc_cnt + 1'b1;
        end
      end
      else if (armed && fall)
      begin
        active  <= 1'b1;
        cyc_cnt <= '0;
        bit_idx <= '0;
      end
      if (bus.start)
        armed <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (active && sample)
    begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8)
        shreg <= {rx_sync, shreg[`UART_READ_WIDTH-1:1]};
      if (bit_idx == 4'd9)
        par_bit <= rx_sync;
      if (bit_idx == 4'd10)
        err <= (par_bit != even_parity(shreg)) || !rx_sync;
    end
  end

  assign bus.data  = shreg;
  assign bus.valid = valid;
  assign bus.busy  = active;
  assign bus.done  = err;

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/10ps

`include "uart_defines.svh"

module uart_tx #(
  parameter int baud_div = `UART_BAUD_DIV
) (
  input  logic           clk,
  input  logic           rst_n,
  uart_byte_if.tx_engine bus,
  output logic           tx
);

  import uart_pkg::*;

  localparam int cnt_w = $clog2(baud_div);

  logic [cnt_w-1:0] cyc_cnt;
  logic [3:0]       bit_idx;
  logic [9:0]       shreg;
  logic             busy;
  logic             done;
  logic             bit_end;
  logic             load;

  assign bit_end = (cyc_cnt == cnt_w'(baud_div - 1));
  assign load    = bus.start && !busy;

  // bit 0 is the start bit, 10 the stop bit.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      done    <= 1'b0;
      tx      <= 1'b1;
      cyc_cnt <= '0;
      bit_idx <= '0;
    end
    else
    begin
      done <= 1'b0;
      if (load)
      begin
        busy    <= 1'b1;
        tx      <= 1'b0;
        cyc_cnt <= '0;
        bit_idx <= '0;
      end
      else if (busy)
      begin
        if (bit_end)
        begin
          cyc_cnt <= '0;
          if (bit_idx == 4'd10)
          begin
            busy <= 1'b0;
            done <= 1'b1;
          end
          else
          begin
            tx      <= shreg[0];
            bit_idx <= bit_idx + 4'd1;
          end
        end
        else
        begin
          cyc_cnt <= cyc_cnt + 1'b1;
        end
      end
    end
  end

  // data lsb first, then parity, then stop.
  always_ff @(posedge clk)
  begin
    if (load)
      shreg <= {1'b1, even_parity(bus.data), bus.data};
    else if (busy && bit_end)
      shreg <= {1'b1, shreg[9:1]};
  end

  assign bus.busy = busy;
  assign bus.done = done;

endmodule

/* hdl/uart_byte_if.sv */
`timescale 1ns/10ps

`include "uart_defines.svh"

interface uart_byte_if;

  logic [`UART_READ_WIDTH-1:0] data;
  logic                        start;
  logic                        busy;
  logic                        done;
  logic                        valid;

  // transmit side.
  modport ctrl_tx   (output data, start, input busy, done);
  modport tx_engine (input data, start, output busy, done);

  // receive side, start arms the receiver and done flags a bad frame.
  modport ctrl_rx   (output start, input data, valid, busy, done);
  modport rx_engine (input start, output data, valid, busy, done);

endinterface

/* hdl/uart_pkg.sv */
`include "uart_defines.svh"

package uart_pkg;

  // wr flag, address, data.
  typedef struct packed {
    logic                                         wr;
    logic [`UART_CMD_WIDTH-`UART_READ_WIDTH-2:0] addr;
    logic [`UART_READ_WIDTH-1:0]                 data;
  } cmd_t;

  typedef enum logic [2:0] {
    st_idle      = 3'd0,
    st_send_hdr  = 3'd1,
    st_gap       = 3'd2,
    st_send_data = 3'd3,
    st_wait_rsp  = 3'd4,
    st_done      = 3'd5
  } ctrl_state_t;

  // even parity bit of a byte.
  function automatic logic even_parity(input logic [`UART_READ_WIDTH-1:0] d);
    return ^d;
  endfunction

endpackage

/* hdl/uart_defines.svh */
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// command and read widths.
`define UART_CMD_WIDTH 16
`define UART_READ_WIDTH 8

// 115200 baud from a 50 MHz clock.
`define UART_BAUD_DIV 434

// idle bit times between header and data of a write.
`define UART_GAP_BITS 15
// bit times a read waits for the response start bit.
`define UART_RSP_TIMEOUT_BITS 64

`endif
